/* Bender.yml */
package:
  name: ppu_core

sources:
  - include_dirs:
      - hw
    files:
      - hw/ppu_pkg.sv
      - hw/ppu_dot_timer.sv
      - hw/ppu_mode_fsm.sv
      - hw/ppu_bus_unit.sv
      - hw/ppu_oam_scan.sv
      - hw/ppu_core.sv
  - target: simulation
    include_dirs:
      - hw
    files:
      - sim/ppu_core_tb.sv

/* hw/ppu_bus_unit.sv */
`include "ppu_params.svh"

module ppu_bus_unit (
  input  logic                  clk,
  input  logic                  reset,
  input  ppu_pkg::cpu_bus_req_t bus_req,
  output logic [7:0]            rdata,
  input  ppu_pkg::ppu_mode_t    mode,
  input  ppu_pkg::ppu_timing_t  timing,
  output ppu_pkg::ppu_regs_t    regs,
  output logic                  lcd_en,
  output logic                  oam_we,
  output logic [7:0]            oam_addr,
  output logic [7:0]            oam_wdata,
  input  logic [7:0]            oam_rdata,
  output logic                  stat_req
);

  logic [7:0]         vram [`PPU_VRAM_BYTES];
  logic [12:0]        vram_idx;
  logic               vram_sel;
  logic               oam_sel;
  logic               vram_open;
  logic               lyc_match;
  logic [7:0]         ly_prev;
  ppu_pkg::ppu_mode_t mode_prev;

  // ============================
  // Address decode
  // ============================
  assign vram_sel = bus_req.addr inside
    {[`PPU_VRAM_BASE : (`PPU_VRAM_BASE + `PPU_VRAM_BYTES - 1)]};
  assign oam_sel = bus_req.addr inside
    {[`PPU_OAM_BASE : (`PPU_OAM_BASE + `PPU_OAM_BYTES - 1)]};
  assign vram_idx = 13'(bus_req.addr - `PPU_VRAM_BASE);

  // VRAM belongs to the renderer during transfer
  assign vram_open = (mode != ppu_pkg::MODE_XFER);

  assign lyc_match = (timing.ly == regs.lyc);
  assign lcd_en    = regs.lcdc[7];

  // OAM lives in the scan stage, never blocked
  assign oam_we    = bus_req.write_en && oam_sel;
  assign oam_addr  = 8'(bus_req.addr - `PPU_OAM_BASE);
  assign oam_wdata = bus_req.wdata;

  // ============================
  // Register writes
  // ============================
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      regs <= '0;
    end else if (bus_req.write_en) begin
      case (bus_req.addr)
        `PPU_REG_LCDC: regs.lcdc <= bus_req.wdata;
        // Only the enables are writable
        `PPU_REG_STAT: regs.stat_en <= bus_req.wdata[6:3];
        `PPU_REG_SCY:  regs.scy <= bus_req.wdata;
        `PPU_REG_SCX:  regs.scx <= bus_req.wdata;
        // LY is read only, falls to default
        `PPU_REG_LYC:  regs.lyc <= bus_req.wdata;
        `PPU_REG_BGP:  regs.bgp <= bus_req.wdata;
        `PPU_REG_WY:   regs.wy <= bus_req.wdata;
        `PPU_REG_WX:   regs.wx <= bus_req.wdata;
        default: ;
      endcase
    end
  end

  // VRAM write port, dropped in mode 3
  always_ff @(posedge clk) begin
    if (bus_req.write_en && vram_sel && vram_open) begin
      vram[vram_idx] <= bus_req.wdata;
    end
  end

  // ============================
  // Read mux
  // ============================
  always_comb begin
    // Open bus reads FFh
    rdata = 8'hFF;
    if (bus_req.read_en) begin
      if (vram_sel) begin
        if (vram_open) begin
          rdata = vram[vram_idx];
        end
      end else if (oam_sel) begin
        rdata = oam_rdata;
      end else begin
        case (bus_req.addr)
          `PPU_REG_LCDC: rdata = regs.lcdc;
          `PPU_REG_STAT: rdata = {1'b1, regs.stat_en, lyc_match, mode};
          `PPU_REG_SCY:  rdata = regs.scy;
          `PPU_REG_SCX:  rdata = regs.scx;
          `PPU_REG_LY:   rdata = timing.ly;
          `PPU_REG_LYC:  rdata = regs.lyc;
          `PPU_REG_BGP:  rdata = regs.bgp;
          `PPU_REG_WY:   rdata = regs.wy;
          `PPU_REG_WX:   rdata = regs.wx;
          default:       rdata = 8'hFF;
        endcase
      end
    end
  end

  // ============================
  // STAT interrupt
  // ============================
  // stat_en[3] LYC, [2] mode 2, [1] mode 1, [0] mode 0
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      stat_req  <= 1'b0;
      ly_prev   <= 8'd0;
      mode_prev <= ppu_pkg::MODE_OAM;
    end else begin
      stat_req  <= 1'b0;
      ly_prev   <= timing.ly;
      mode_prev <= mode;
      // LY match wins over mode entry
      if (regs.stat_en[3] && timing.ly != ly_prev && lyc_match) begin
        stat_req <= 1'b1;
      end else if (mode != mode_prev) begin
        case (mode)
          ppu_pkg::MODE_OAM:    stat_req <= regs.stat_en[2];
          ppu_pkg::MODE_VBLANK: stat_req <= regs.stat_en[1];
          ppu_pkg::MODE_HBLANK: stat_req <= regs.stat_en[0];
          default:              stat_req <= 1'b0;
        endcase
      end
    end
  end

  // Host never reads and writes in the same cycle
  no_rd_wr_overlap: assert property (@(posedge clk) disable iff (reset)
    !(bus_req.read_en && bus_req.write_en));

endmodule

/* hw/ppu_core.sv */
`include "ppu_params.svh"

module ppu_core (
  input  logic                  clk,
  input  logic                  reset,
  input  ppu_pkg::cpu_bus_req_t bus_req,
  output logic [7:0]            rdata,
  output logic                  vblank_req,
  output logic                  stat_req,
  output ppu_pkg::ppu_mode_t    mode,
  output ppu_pkg::sprite_t      sprites [`PPU_MAX_SPRITES],
  output logic [3:0]            sprite_count
);

  ppu_pkg::ppu_regs_t   regs;
  ppu_pkg::ppu_timing_t timing;
  logic                 lcd_en;
  logic                 oam_we;
  logic [7:0]           oam_addr;
  logic [7:0]           oam_wdata;
  logic [7:0]           oam_rdata;

  // ============================
  // Timing
  // ============================
  ppu_dot_timer timer_i (
    .clk        (clk),
    .reset      (reset),
    .lcd_en     (lcd_en),
    .timing     (timing),
    .vblank_req (vblank_req)
  );

  ppu_mode_fsm fsm_i (
    .clk    (clk),
    .reset  (reset),
    .lcd_en (lcd_en),
    .timing (timing),
    .mode   (mode)
  );

  // ============================
  // Host side and OAM scan
  // ============================
  ppu_bus_unit bus_i (
    .clk       (clk),
    .reset     (reset),
    .bus_req   (bus_req),
    .rdata     (rdata),
    .mode      (mode),
    .timing    (timing),
    .regs      (regs),
    .lcd_en    (lcd_en),
    .oam_we    (oam_we),
    .oam_addr  (oam_addr),
    .oam_wdata (oam_wdata),
    .oam_rdata (oam_rdata),
    .stat_req  (stat_req)
  );

  // Object list goes out for the renderer
  ppu_oam_scan scan_i (
    .clk          (clk),
    .reset        (reset),
    .oam_we       (oam_we),
    .oam_addr     (oam_addr),
    .oam_wdata    (oam_wdata),
    .oam_rdata    (oam_rdata),
    .regs         (regs),
    .timing       (timing),
    .mode         (mode),
    .sprites      (sprites),
    .sprite_count (sprite_count)
  );

endmodule

/* hw/ppu_dot_timer.sv */
`include "ppu_params.svh"

module ppu_dot_timer (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 lcd_en,
  output ppu_pkg::ppu_timing_t timing,
  output logic                 vblank_req
);

  logic [8:0] dot;
  logic [7:0] ly;
  logic       last_dot;
  logic       last_line;

  // End of line and end of frame flags
  assign last_dot  = (dot == 9'(`PPU_DOTS_PER_LINE - 1));
  assign last_line = (ly == 8'(`PPU_LINES_PER_FRAME - 1));

  // ============================
  // Dot and line counters
  // ============================
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      dot        <= 9'd0;
      ly         <= 8'd0;
      vblank_req <= 1'b0;
    end else begin
      // Strobe lasts one cycle only
      vblank_req <= 1'b0;
      if (!lcd_en) begin
        // LCD off, hold at top of frame
        dot <= 9'd0;
        ly  <= 8'd0;
      end else if (last_dot) begin
        dot <= 9'd0;
        ly  <= last_line ? 8'd0 : ly + 8'd1;
        // Line 144 starts at this edge
        if (ly == 8'(`PPU_VISIBLE_LINES - 1)) begin
          vblank_req <= 1'b1;
        end
      end else begin
        dot <= dot + 9'd1;
      end
    end
  end

  assign timing = '{
    dot:       dot,
    ly:        ly,
    line_end:  last_dot,
    frame_end: last_dot && last_line
  };

  // Dot must wrap before reaching the line length
  dot_in_line: assert property (@(posedge clk) disable iff (reset)
    dot <= 9'(`PPU_DOTS_PER_LINE - 1));

endmodule

/* hw/ppu_mode_fsm.sv */
`include "ppu_params.svh"

module ppu_mode_fsm (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 lcd_en,
  input  ppu_pkg::ppu_timing_t timing,
  output ppu_pkg::ppu_mode_t   mode
);

  logic xfer_start;
  logic xfer_end;
  logic enter_vblank;

  // ============================
  // Boundary decode
  // ============================
  // Decided on the dot before the boundary
  // so the registered mode lines up with dot
  assign xfer_start = (timing.dot == 9'(`PPU_MODE2_LEN - 1));
  assign xfer_end   = (timing.dot == 9'(`PPU_MODE2_LEN + `PPU_MODE3_LEN - 1));
  // Last visible line about to wrap into 144
  assign enter_vblank = (timing.ly == 8'(`PPU_VISIBLE_LINES - 1));

  // ============================
  // Mode register
  // ============================
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      mode <= ppu_pkg::MODE_OAM;
    end else if (!lcd_en) begin
      // Parked in OAM scan while off
      mode <= ppu_pkg::MODE_OAM;
    end else begin
      unique case (mode)
        ppu_pkg::MODE_OAM: begin
          if (xfer_start) begin
            mode <= ppu_pkg::MODE_XFER;
          end
        end
        ppu_pkg::MODE_XFER: begin
          // Fixed length transfer
          if (xfer_end) begin
            mode <= ppu_pkg::MODE_HBLANK;
          end
        end
        ppu_pkg::MODE_HBLANK: begin
          if (timing.line_end) begin
            mode <= enter_vblank ? ppu_pkg::MODE_VBLANK : ppu_pkg::MODE_OAM;
          end
        end
        ppu_pkg::MODE_VBLANK: begin
          // Wrap to line 0
          if (timing.frame_end) begin
            mode <= ppu_pkg::MODE_OAM;
          end
        end
        default: mode <= ppu_pkg::MODE_OAM;
      endcase
    end
  end

  // Transfer only ever hands over to HBlank, right at the end dot
  xfer_to_hblank: assert property (@(posedge clk) disable iff (reset)
    (mode == ppu_pkg::MODE_XFER && lcd_en) |=>
      (mode == ppu_pkg::MODE_XFER) ||
      (mode == ppu_pkg::MODE_HBLANK &&
       timing.dot == 9'(`PPU_MODE2_LEN + `PPU_MODE3_LEN)));

endmodule

/* hw/ppu_oam_scan.sv */
`include "ppu_params.svh"

module ppu_oam_scan (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 oam_we,
  input  logic [7:0]           oam_addr,
  input  logic [7:0]           oam_wdata,
  output logic [7:0]           oam_rdata,
  input  ppu_pkg::ppu_regs_t   regs,
  input  ppu_pkg::ppu_timing_t timing,
  input  ppu_pkg::ppu_mode_t   mode,
  output ppu_pkg::sprite_t     sprites [`PPU_MAX_SPRITES],
  output logic [3:0]           sprite_count
);

  logic [7:0]       oam [`PPU_OAM_BYTES];
  logic [5:0]       entry;
  logic [7:0]       entry_base;
  logic [8:0]       line_pos;
  logic [8:0]       obj_height;
  logic             lcd_on;
  logic             scan_slot;
  logic             obj_hit;
  ppu_pkg::sprite_t cand;

  // ============================
  // OAM storage
  // ============================
  always_ff @(posedge clk) begin
    if (oam_we) begin
      oam[oam_addr] <= oam_wdata;
    end
  end

  // Host read, combinational
  assign oam_rdata = oam[oam_addr];

  // ============================
  // Candidate entry
  // ============================
  // Two dots per entry, four bytes each
  assign entry      = timing.dot[6:1];
  assign entry_base = {entry, 2'b00};
  assign lcd_on     = regs.lcdc[7];
  // LCDC bit 2 selects 8x16 objects
  assign obj_height = regs.lcdc[2] ? 9'd16 : 9'd8;
  // Line in object Y space, 9 bits to avoid wrap
  assign line_pos   = {1'b0, timing.ly} + 9'd16;

  always_comb begin
    cand.y_pos    = oam[entry_base];
    cand.x_pos    = oam[entry_base + 8'd1];
    cand.tile_idx = oam[entry_base + 8'd2];
    cand.attr     = oam[entry_base + 8'd3];
    cand.oam_idx  = entry;
    cand.valid    = 1'b1;
  end

  // Object covers the current line
  assign obj_hit = (line_pos >= {1'b0, cand.y_pos}) &&
                   (line_pos < ({1'b0, cand.y_pos} + obj_height));

  // First dot of each entry, room left in the buffer
  assign scan_slot = lcd_on && (mode == ppu_pkg::MODE_OAM) && !timing.dot[0] &&
                     (sprite_count < 4'(`PPU_MAX_SPRITES));

  // ============================
  // Object buffer
  // ============================
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      sprites      <= '{default: '0};
      sprite_count <= 4'd0;
    end else if (timing.line_end || !lcd_on) begin
      // Fresh list for each line
      sprites      <= '{default: '0};
      sprite_count <= 4'd0;
    end else if (scan_slot && obj_hit) begin
      sprites[sprite_count] <= cand;
      sprite_count          <= sprite_count + 4'd1;
    end
  end

  count_capped: assert property (@(posedge clk) disable iff (reset)
    sprite_count <= 4'(`PPU_MAX_SPRITES));

endmodule

/* hw/ppu_params.svh */
`ifndef PPU_PARAMS_SVH
`define PPU_PARAMS_SVH

// ============================
// Line and frame timing
// ============================
`define PPU_DOTS_PER_LINE   456
`define PPU_LINES_PER_FRAME 154
`define PPU_VISIBLE_LINES   144
`define PPU_MODE2_LEN       80
// Fixed, no renderer to end the transfer early
`define PPU_MODE3_LEN       172

// ============================
// Memories
// ============================
`define PPU_VRAM_BYTES  8192
`define PPU_OAM_BYTES   160
`define PPU_MAX_SPRITES 10

// Memory base addresses on the host bus
`define PPU_VRAM_BASE 16'h8000
`define PPU_OAM_BASE  16'hFE00

// LCD register addresses
`define PPU_REG_LCDC 16'hFF40
`define PPU_REG_STAT 16'hFF41
`define PPU_REG_SCY  16'hFF42
`define PPU_REG_SCX  16'hFF43
`define PPU_REG_LY   16'hFF44
`define PPU_REG_LYC  16'hFF45
// FF46h is DMA, not decoded here
`define PPU_REG_BGP  16'hFF47
`define PPU_REG_WY   16'hFF4A
`define PPU_REG_WX   16'hFF4B

`endif

/* hw/ppu_pkg.sv */
package ppu_pkg;

  // ============================
  // PPU mode, as seen in STAT[1:0]
  // ============================
  typedef enum logic [1:0] {
    MODE_HBLANK = 2'd0,
    MODE_VBLANK = 2'd1,
    MODE_OAM    = 2'd2,
    MODE_XFER   = 2'd3
  } ppu_mode_t;

  // LCD register file
  typedef struct packed {
    logic [7:0] lcdc;
    // STAT bits 6..3, the interrupt enables
    logic [3:0] stat_en;
    logic [7:0] scy;
    logic [7:0] scx;
    logic [7:0] lyc;
    logic [7:0] bgp;
    logic [7:0] wy;
    logic [7:0] wx;
  } ppu_regs_t;

  // Host bus request, plain strobes
  typedef struct packed {
    logic [15:0] addr;
    logic [7:0]  wdata;
    logic        read_en;
    logic        write_en;
  } cpu_bus_req_t;

  // Dot and line position from the timer
  typedef struct packed {
    logic [8:0] dot;
    logic [7:0] ly;
    logic       line_end;
    logic       frame_end;
  } ppu_timing_t;

  // One object picked by the OAM scan
  typedef struct packed {
    logic [7:0] y_pos;
    logic [7:0] x_pos;
    logic [7:0] tile_idx;
    logic [7:0] attr;
    logic [5:0] oam_idx;
    logic       valid;
  } sprite_t;

endpackage

/* ppu_core.f */
+incdir+hw
hw/ppu_pkg.sv
hw/ppu_dot_timer.sv
hw/ppu_mode_fsm.sv
hw/ppu_bus_unit.sv
hw/ppu_oam_scan.sv
hw/ppu_core.sv
sim/ppu_core_tb.sv

/* sim/ppu_core_tb.sv */
`include "ppu_params.svh"

module ppu_core_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int FRAME_CYCLES = `PPU_DOTS_PER_LINE * `PPU_LINES_PER_FRAME;
  // Three frames plus room for the register and fill phases
  localparam int LIMIT_NS = (3 * FRAME_CYCLES + 20000) * 20;

  logic                  clk;
  logic                  reset;
  ppu_pkg::cpu_bus_req_t bus_req;
  logic [7:0]            rdata;
  logic                  vblank_req;
  logic                  stat_req;
  ppu_pkg::ppu_mode_t    mode;
  ppu_pkg::sprite_t      sprites [`PPU_MAX_SPRITES];
  logic [3:0]            sprite_count;

  integer seed;
  int     errors;
  int     vblank_seen;
  logic   scan_check;
  string  phase;

  // ============================
  // Reference model state
  // ============================
  logic [8:0]         m_dot;
  logic [7:0]         m_ly;
  logic [7:0]         m_ly_prev;
  ppu_pkg::ppu_mode_t m_mode;
  ppu_pkg::ppu_mode_t m_mode_prev;
  logic               m_vblank;
  logic               m_stat_req;
  // Register shadow, indexed by address minus FF40h
  logic [7:0]         m_reg [16];
  logic [7:0]         m_vram [`PPU_VRAM_BYTES];
  logic [7:0]         m_oam [`PPU_OAM_BYTES];
  ppu_pkg::sprite_t   exp_spr [`PPU_MAX_SPRITES];
  int                 exp_cnt;

  ppu_core dut_i (
    .clk          (clk),
    .reset        (reset),
    .bus_req      (bus_req),
    .rdata        (rdata),
    .vblank_req   (vblank_req),
    .stat_req     (stat_req),
    .mode         (mode),
    .sprites      (sprites),
    .sprite_count (sprite_count)
  );

  always #10 clk = ~clk;

  // Mode from the position after the edge
  function automatic ppu_pkg::ppu_mode_t mode_for(input logic [8:0] dot, input logic [7:0] ly);
    if (ly >= `PPU_VISIBLE_LINES) return ppu_pkg::MODE_VBLANK;
    if (dot < `PPU_MODE2_LEN) return ppu_pkg::MODE_OAM;
    if (dot < `PPU_MODE2_LEN + `PPU_MODE3_LEN) return ppu_pkg::MODE_XFER;
    return ppu_pkg::MODE_HBLANK;
  endfunction

  // VRAM preload pattern over all 13 address bits
  function automatic logic [7:0] fill_byte(input logic [12:0] a);
    return a[7:0] ^ {a[12:8], a[12:10]} ^ 8'hA5;
  endfunction

  function automatic logic [7:0] expected_read(input logic [15:0] addr);
    if (addr >= `PPU_VRAM_BASE && addr < `PPU_VRAM_BASE + `PPU_VRAM_BYTES) begin
      // Blocked while the renderer owns VRAM
      return (m_mode == ppu_pkg::MODE_XFER) ? 8'hFF : m_vram[13'(addr - `PPU_VRAM_BASE)];
    end
    if (addr >= `PPU_OAM_BASE && addr < `PPU_OAM_BASE + `PPU_OAM_BYTES) begin
      return m_oam[8'(addr - `PPU_OAM_BASE)];
    end
    if (addr == `PPU_REG_STAT) return {1'b1, m_reg[1][6:3], m_ly == m_reg[5], m_mode};
    if (addr == `PPU_REG_LY) return m_ly;
    if (addr inside {`PPU_REG_LCDC, `PPU_REG_SCY, `PPU_REG_SCX, `PPU_REG_LYC,
                     `PPU_REG_BGP, `PPU_REG_WY, `PPU_REG_WX}) begin
      return m_reg[4'(addr - `PPU_REG_LCDC)];
    end
    return 8'hFF;
  endfunction

  // In-order pick of the first ten objects on a line
  task automatic select_objects(input logic [7:0] line, input logic tall);
    int line_pos;
    int height;
    int y;
    line_pos = int'(line) + 16;
    height = tall ? 16 : 8;
    exp_cnt = 0;
    for (int i = 0; i < `PPU_MAX_SPRITES; i++) exp_spr[i] = '0;
    for (int i = 0; i < `PPU_OAM_BYTES / 4; i++) begin
      y = int'(m_oam[4 * i]);
      if (exp_cnt < `PPU_MAX_SPRITES && line_pos >= y && line_pos < y + height) begin
        exp_spr[exp_cnt] = '{y_pos: m_oam[4 * i], x_pos: m_oam[4 * i + 1],
                             tile_idx: m_oam[4 * i + 2], attr: m_oam[4 * i + 3],
                             oam_idx: 6'(i), valid: 1'b1};
        exp_cnt++;
      end
    end
  endtask

  task automatic report(input string what, input logic [38:0] exp_v, input logic [38:0] act_v);
    errors++;
    $display("FAIL %s %s expected %h actual %h", phase, what, exp_v, act_v);
  endtask

  task automatic check_sprites();
    select_objects(m_ly, m_reg[0][2]);
    if (sprite_count !== 4'(exp_cnt)) report("sprite_count", exp_cnt, sprite_count);
    for (int i = 0; i < `PPU_MAX_SPRITES; i++) begin
      if (sprites[i] !== exp_spr[i]) report("sprite entry", exp_spr[i], sprites[i]);
    end
  endtask

  // One bus cycle, driven at the rising edge
  task automatic issue(input logic [15:0] addr, input logic [7:0] data,
                       input logic rd, input logic wr);
    @(posedge clk);
    bus_req <= '{addr: addr, wdata: data, read_en: rd, write_en: wr};
  endtask

  // ============================
  // Model step at each edge
  // ============================
  always @(posedge clk) begin
    ppu_pkg::cpu_bus_req_t req;
    logic lcd_on;
    req = bus_req;
    if (reset) begin
      m_dot = '0;
      m_ly = '0;
      m_ly_prev = '0;
      m_mode = ppu_pkg::MODE_OAM;
      m_mode_prev = ppu_pkg::MODE_OAM;
      m_vblank = 1'b0;
      m_stat_req = 1'b0;
      for (int i = 0; i < 16; i++) m_reg[i] = '0;
    end else begin
      lcd_on = m_reg[0][7];
      // STAT strobe one cycle after LY match or mode entry
      m_stat_req = 1'b0;
      if (m_reg[1][6] && m_ly != m_ly_prev && m_ly == m_reg[5]) begin
        m_stat_req = 1'b1;
      end else if (m_mode != m_mode_prev) begin
        case (m_mode)
          ppu_pkg::MODE_OAM:    m_stat_req = m_reg[1][5];
          ppu_pkg::MODE_VBLANK: m_stat_req = m_reg[1][4];
          ppu_pkg::MODE_HBLANK: m_stat_req = m_reg[1][3];
          default:              m_stat_req = 1'b0;
        endcase
      end
      m_ly_prev = m_ly;
      m_mode_prev = m_mode;
      // Host writes, VRAM checked against the mode before the edge
      if (req.write_en) begin
        if (req.addr >= `PPU_VRAM_BASE && req.addr < `PPU_VRAM_BASE + `PPU_VRAM_BYTES) begin
          if (m_mode != ppu_pkg::MODE_XFER) m_vram[13'(req.addr - `PPU_VRAM_BASE)] = req.wdata;
        end else if (req.addr >= `PPU_OAM_BASE &&
                     req.addr < `PPU_OAM_BASE + `PPU_OAM_BYTES) begin
          m_oam[8'(req.addr - `PPU_OAM_BASE)] = req.wdata;
        end else if (req.addr == `PPU_REG_STAT) begin
          m_reg[1] = req.wdata & 8'h78;
        end else if (req.addr inside {`PPU_REG_LCDC, `PPU_REG_SCY, `PPU_REG_SCX, `PPU_REG_LYC,
                                      `PPU_REG_BGP, `PPU_REG_WY, `PPU_REG_WX}) begin
          m_reg[4'(req.addr - `PPU_REG_LCDC)] = req.wdata;
        end
      end
      // Dot and line count
      m_vblank = 1'b0;
      if (!lcd_on) begin
        m_dot = '0;
        m_ly = '0;
      end else if (m_dot == `PPU_DOTS_PER_LINE - 1) begin
        m_dot = '0;
        m_ly = (m_ly == `PPU_LINES_PER_FRAME - 1) ? 8'd0 : m_ly + 8'd1;
        m_vblank = (m_ly == `PPU_VISIBLE_LINES);
      end else begin
        m_dot = m_dot + 9'd1;
      end
      m_mode = mode_for(m_dot, m_ly);
    end
  end

  // Compare on the falling edge, outputs settled
  always @(negedge clk) begin
    if (!reset) begin
      if (mode !== m_mode) report("mode", m_mode, mode);
      if (vblank_req !== m_vblank) report("vblank_req", m_vblank, vblank_req);
      if (stat_req !== m_stat_req) report("stat_req", m_stat_req, stat_req);
      if (vblank_req === 1'b1) vblank_seen++;
      if (bus_req.read_en && rdata !== expected_read(bus_req.addr)) begin
        report($sformatf("rdata at %h", bus_req.addr), expected_read(bus_req.addr), rdata);
      end
      // Object list is complete well before dot 100
      if (scan_check && m_reg[0][7] && m_ly < `PPU_VISIBLE_LINES && m_dot == 9'd100) begin
        check_sprites();
      end
    end
  end

  initial begin
    #(LIMIT_NS);
    $display("timeout, the run did not reach its end in time");
    $display("tests failed");
    $finish;
  end

  // ============================
  // Stimulus
  // ============================
  initial begin
    logic [31:0] r;
    logic [12:0] win;
    clk = 1'b0;
    reset = 1'b1;
    bus_req = '0;
    seed = 91;
    errors = 0;
    vblank_seen = 0;
    scan_check = 1'b0;
    phase = "reset";
    repeat (5) @(posedge clk);
    reset <= 1'b0;

    // Register file, LY, STAT and open bus
    phase = "regs";
    repeat (400) begin
      r = $unsigned($random(seed));
      case (r[1:0])
        2'd0: issue(16'hFF40 + 16'(r[11:8]), r[23:16], 1'b0, 1'b1);
        2'd1: issue(16'hFF40 + 16'(r[11:8]), 8'h00, 1'b1, 1'b0);
        2'd2: issue(16'hC000 | 16'(r[20:8]), 8'h00, 1'b1, 1'b0);
        default: issue(16'hFEA0 + 16'(r[15:8] % 8'd96), 8'h00, 1'b1, 1'b0);
      endcase
    end
    issue(`PPU_REG_LCDC, 8'h00, 1'b0, 1'b1);

    // Preload a 256 byte VRAM window with the LCD off
    phase = "vram_fill";
    win = 13'($unsigned($random(seed))) & 13'h1F00;
    for (int i = 0; i < 256; i++) begin
      issue(`PPU_VRAM_BASE + 16'(win) + 16'(i), fill_byte(win + 13'(i)), 1'b0, 1'b1);
    end
    repeat (32) issue(`PPU_VRAM_BASE + 16'(win) + 16'($random(seed) & 255), 8'h00, 1'b1, 1'b0);

    // One full frame with random host traffic
    phase = "frame";
    issue(`PPU_REG_STAT, 8'($random(seed)), 1'b0, 1'b1);
    issue(`PPU_REG_LYC, 8'($unsigned($random(seed)) % 154), 1'b0, 1'b1);
    issue(`PPU_REG_LCDC, 8'h80, 1'b0, 1'b1);
    vblank_seen = 0;
    repeat (FRAME_CYCLES) begin
      r = $unsigned($random(seed));
      case (r[2:0])
        3'd0: issue(`PPU_REG_LY, 8'h00, 1'b1, 1'b0);
        3'd1: issue(`PPU_REG_STAT, 8'h00, 1'b1, 1'b0);
        3'd2, 3'd3: issue(`PPU_VRAM_BASE + 16'(win) + 16'(r[15:8]), r[23:16], 1'b0, 1'b1);
        3'd4: issue(`PPU_VRAM_BASE + 16'(win) + 16'(r[15:8]), 8'h00, 1'b1, 1'b0);
        default: issue(16'h0000, 8'h00, 1'b0, 1'b0);
      endcase
    end
    if (vblank_seen != 1) report("vblank pulses per frame", 1, vblank_seen);

    // LCD off parks the timer
    phase = "lcd_off";
    issue(`PPU_REG_LCDC, 8'h00, 1'b0, 1'b1);
    repeat (2) issue(16'h0000, 8'h00, 1'b0, 1'b0);
    issue(`PPU_REG_LY, 8'h00, 1'b1, 1'b0);
    @(negedge clk);
    if (mode !== ppu_pkg::MODE_OAM) report("mode after LCD off", ppu_pkg::MODE_OAM, mode);

    // Object search, 8x8 then 8x16
    for (int tall = 0; tall < 2; tall++) begin
      phase = (tall != 0) ? "objects_8x16" : "objects_8x8";
      issue(`PPU_REG_LCDC, 8'h00, 1'b0, 1'b1);
      for (int i = 0; i < `PPU_OAM_BYTES; i++) begin
        r = $unsigned($random(seed));
        // Y bytes packed near the top lines
        issue(`PPU_OAM_BASE + 16'(i), (i % 4 == 0) ? 8'(8 + r % 56) : r[7:0], 1'b0, 1'b1);
      end
      repeat (16) begin
        issue(`PPU_OAM_BASE + 16'($unsigned($random(seed)) % 160), 8'h00, 1'b1, 1'b0);
      end
      issue(`PPU_REG_LCDC, 8'h80 | 8'(tall << 2), 1'b0, 1'b1);
      scan_check = 1'b1;
      repeat (48 * `PPU_DOTS_PER_LINE) issue(16'h0000, 8'h00, 1'b0, 1'b0);
      scan_check = 1'b0;
    end

    repeat (4) issue(16'h0000, 8'h00, 1'b0, 1'b0);
    $display("%0d errors", errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule
